//--- src/frontend_settings.svh
// ====================
// Build constants for the instruction-supply front end.
// Included by the package and by any module that needs a width,
// the reset address, the buffer depth or an exception code.
// ====================

`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// Width of fetch addresses and instruction words
`define FE_XLEN 32

// First address fetched once reset is released
`define FE_RESET_PC 32'h0000_0100

// Buffer entries, which also bounds the number of fetches in flight
`define FE_IBUF_DEPTH 4

// Exception codes reported in the decoded packet
`define FE_EXC_MISALIGNED 5'd0
`define FE_EXC_ILLEGAL 5'd2

`endif

//--- src/frontend_pkg.sv
// ====================
// Types shared by the front-end RTL and its testbench.
// Modules pull them in with a wildcard import in the module header.
// ====================

`include "frontend_settings.svh"

package frontend_pkg;

    // Fetch request strobe and address towards instruction memory
    typedef struct packed {
        logic               req;
        logic [`FE_XLEN-1:0] addr;
    } fetch_req_t;

    // One response per accepted request, returned in order
    typedef struct packed {
        logic               valid;
        logic [`FE_XLEN-1:0] word;
    } fetch_rsp_t;

    // Control-flow changes reported by the back end, flags are one-cycle pulses
    typedef struct packed {
        logic               exception;
        logic               handler_return;
        logic               branch_taken;
        logic [`FE_XLEN-1:0] handler_pc;
        logic [`FE_XLEN-1:0] return_pc;
        logic [`FE_XLEN-1:0] branch_target;
    } redirect_t;

    typedef enum logic [3:0] {
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_LOAD,
        OP_STORE,
        OP_ALU_IMM,
        OP_ALU_REG,
        OP_MUL,
        OP_FENCE,
        OP_SYSTEM,
        OP_ILLEGAL
    } op_class_e;

    typedef struct packed {
        logic               valid;
        logic [`FE_XLEN-1:0] pc;
        op_class_e          op_class;
        logic [4:0]         rd;
        logic [4:0]         rs1;
        logic [4:0]         rs2;
        logic [`FE_XLEN-1:0] imm;
        logic               exception;
        logic [4:0]         exc_code;
    } decoded_t;

endpackage

//--- src/redirect_hold.sv
// ====================
// Holding register for a redirect that cannot be fetched yet.
// Sits beside pc_gen and keeps the winning target until fetch is free.
// ====================

`timescale 1ns/1ps

module redirect_hold import frontend_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  redirect_t   redirect_i,
    input  logic        fetch_blocked_i,
    output logic        pending_o,
    output logic [31:0] pending_target_o
);

    logic        any_redirect;
    logic [31:0] resolved_target;
    logic        pending_q;
    logic [31:0] target_q;

    assign any_redirect = redirect_i.exception | redirect_i.handler_return |
                          redirect_i.branch_taken;

    // Exception wins over handler return, which wins over a taken branch
    always_comb begin
        if (redirect_i.exception) begin
            resolved_target = redirect_i.handler_pc;
        end else if (redirect_i.handler_return) begin
            resolved_target = redirect_i.return_pc;
        end else begin
            resolved_target = redirect_i.branch_target;
        end
    end

    // A newer redirect simply overwrites whatever is held
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else if (any_redirect & fetch_blocked_i) begin
            pending_q <= 1'b1;
        end else if (!fetch_blocked_i) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (any_redirect) begin
            target_q <= resolved_target;
        end
    end

    assign pending_o        = pending_q;
    assign pending_target_o = target_q;

endmodule

//--- src/pc_gen.sv
// ====================
// Program counter generation.
// Picks the next fetch address by redirect priority and drives the
// request strobe; the squash pulse marks every new redirect.
// ====================

`timescale 1ns/1ps

`include "frontend_settings.svh"

module pc_gen import frontend_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  redirect_t   redirect_i,
    input  logic        pending_i,
    input  logic [31:0] pending_target_i,
    input  logic        fetch_stall_i,
    input  logic        ibuf_full_i,
    output fetch_req_t  fetch_req_o,
    output logic        fetch_blocked_o,
    output logic        squash_o
);

    logic [31:0] next_pc_q;
    logic [31:0] fetch_addr;
    logic        started_q;
    logic        accepted;

    // Live redirects first, then a held one, then the sequential path
    always_comb begin
        if (redirect_i.exception) begin
            fetch_addr = redirect_i.handler_pc;
        end else if (redirect_i.handler_return) begin
            fetch_addr = redirect_i.return_pc;
        end else if (redirect_i.branch_taken) begin
            fetch_addr = redirect_i.branch_target;
        end else if (pending_i) begin
            fetch_addr = pending_target_i;
        end else begin
            fetch_addr = next_pc_q;
        end
    end

    assign fetch_req_o.req  = started_q & !ibuf_full_i;
    assign fetch_req_o.addr = fetch_addr;
    assign accepted         = fetch_req_o.req & !fetch_stall_i;

    // The cycle right after reset issues nothing, so treat it as blocked
    assign fetch_blocked_o = fetch_stall_i | ibuf_full_i | !started_q;

    assign squash_o = redirect_i.exception | redirect_i.handler_return |
                      redirect_i.branch_taken;

    // next_pc_q holds the sequential address and only moves on acceptance
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            started_q <= 1'b0;
            next_pc_q <= `FE_RESET_PC;
        end else begin
            started_q <= 1'b1;
            if (accepted) begin
                next_pc_q <= fetch_addr + 32'd4;
            end
        end
    end

endmodule

//--- src/instr_buffer.sv
// ====================
// Instruction buffer between memory and decode.
// Pairs each response with the address it was fetched from, counts
// fetches in flight and drops responses belonging to a squashed path.
// ====================

`timescale 1ns/1ps

`include "frontend_settings.svh"

module instr_buffer import frontend_pkg::*; #(
    parameter int DEPTH = `FE_IBUF_DEPTH
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        squash_i,
    input  logic        accepted_i,
    input  logic [31:0] fetch_addr_i,
    input  fetch_rsp_t  fetch_rsp_i,
    input  logic        read_i,
    output logic [31:0] word_o,
    output logic [31:0] pc_o,
    output logic        empty_o,
    output logic        full_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [31:0]      word_mem [DEPTH];
    logic [31:0]      pc_mem   [DEPTH];
    logic [31:0]      addr_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [PTR_W-1:0] awr_ptr_q, ard_ptr_q, awr_slot;
    logic [CNT_W-1:0] count_q, outstanding_q, discard_q;
    logic [CNT_W+1:0] occupancy;
    logic             stale_rsp, write_en, pop_en;

    assign stale_rsp = fetch_rsp_i.valid & (discard_q != '0);
    assign write_en  = fetch_rsp_i.valid & !stale_rsp & !squash_i;
    assign pop_en    = read_i & (count_q != '0);

    // A request accepted with the squash is the first of the new path
    assign awr_slot = squash_i ? '0 : awr_ptr_q;

    // Stored words, valid fetches and stale fetches all hold a slot
    assign occupancy = {2'b00, count_q} + {2'b00, outstanding_q} + {2'b00, discard_q};
    assign full_o    = occupancy >= (CNT_W+2)'(DEPTH);

    always_ff @(posedge clk_i) begin
        if (accepted_i) begin
            addr_mem[awr_slot] <= fetch_addr_i;
        end
        if (write_en) begin
            word_mem[wr_ptr_q] <= fetch_rsp_i.word;
            pc_mem[wr_ptr_q]   <= addr_mem[ard_ptr_q];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            awr_ptr_q     <= '0;
            ard_ptr_q     <= '0;
            count_q       <= '0;
            outstanding_q <= '0;
            discard_q     <= '0;
        end else if (squash_i) begin
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            ard_ptr_q     <= '0;
            count_q       <= '0;
            awr_ptr_q     <= accepted_i ? PTR_W'(1) : '0;
            outstanding_q <= accepted_i ? CNT_W'(1) : '0;
            // Everything still in flight now belongs to the old path
            discard_q     <= discard_q + outstanding_q - CNT_W'(fetch_rsp_i.valid);
        end else begin
            if (accepted_i) begin
                awr_ptr_q <= awr_ptr_q + 1'b1;
            end
            if (write_en) begin
                wr_ptr_q  <= wr_ptr_q + 1'b1;
                ard_ptr_q <= ard_ptr_q + 1'b1;
            end
            if (pop_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (stale_rsp) begin
                discard_q <= discard_q - 1'b1;
            end
            count_q       <= count_q + CNT_W'(write_en) - CNT_W'(pop_en);
            outstanding_q <= outstanding_q + CNT_W'(accepted_i) - CNT_W'(write_en);
        end
    end

    assign word_o  = word_mem[rd_ptr_q];
    assign pc_o    = pc_mem[rd_ptr_q];
    assign empty_o = (count_q == '0);

endmodule

//--- src/instr_decode.sv
// ====================
// Decode stage.
// Classifies the buffered word, extracts registers and immediate,
// flags exceptions and registers one packet per instruction.
// ====================

`timescale 1ns/1ps

`include "frontend_settings.svh"

module instr_decode import frontend_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        squash_i,
    input  logic        stall_i,
    input  logic        m_ext_i,
    input  logic [31:0] word_i,
    input  logic [31:0] pc_i,
    input  logic        empty_i,
    output logic        read_o,
    output decoded_t    decoded_o
);

    logic [6:0]  opcode;
    logic [6:0]  funct7;
    logic        misaligned;
    logic        illegal;
    op_class_e   op_class;
    logic [31:0] imm;
    decoded_t    packet_d;
    decoded_t    decoded_q;

    assign opcode = word_i[6:0];
    assign funct7 = word_i[31:25];

    // ====================
    // Classification
    // ====================

    always_comb begin
        case (opcode)
            7'b0110111: op_class = OP_LUI;
            7'b0010111: op_class = OP_AUIPC;
            7'b1101111: op_class = OP_JAL;
            7'b1100111: op_class = OP_JALR;
            7'b1100011: op_class = OP_BRANCH;
            7'b0000011: op_class = OP_LOAD;
            7'b0100011: op_class = OP_STORE;
            7'b0010011: op_class = OP_ALU_IMM;
            7'b0001111: op_class = OP_FENCE;
            7'b1110011: op_class = OP_SYSTEM;
            7'b0110011: begin
                // funct7 of 1 selects the M extension group
                if (funct7 == 7'b0000001) begin
                    op_class = m_ext_i ? OP_MUL : OP_ILLEGAL;
                end else begin
                    op_class = OP_ALU_REG;
                end
            end
            default:    op_class = OP_ILLEGAL;
        endcase
    end

    // Immediate in the RV32I format of the class, sign extended
    always_comb begin
        case (op_class)
            OP_LUI, OP_AUIPC: imm = {word_i[31:12], 12'b0};
            OP_JAL:    imm = {{12{word_i[31]}}, word_i[19:12], word_i[20], word_i[30:21], 1'b0};
            OP_BRANCH: imm = {{20{word_i[31]}}, word_i[7], word_i[30:25], word_i[11:8], 1'b0};
            OP_STORE:  imm = {{21{word_i[31]}}, word_i[30:25], word_i[11:7]};
            OP_JALR, OP_LOAD, OP_ALU_IMM, OP_FENCE, OP_SYSTEM:
                       imm = {{21{word_i[31]}}, word_i[30:20]};
            default:   imm = '0;
        endcase
    end

    // ====================
    // Packet and stage register
    // ====================

    assign misaligned = (pc_i[1:0] != 2'b00);
    assign illegal    = (op_class == OP_ILLEGAL);
    assign read_o     = !stall_i & !empty_i;

    always_comb begin
        packet_d.valid     = !empty_i;
        packet_d.pc        = pc_i;
        packet_d.op_class  = op_class;
        packet_d.rd        = word_i[11:7];
        packet_d.rs1       = word_i[19:15];
        packet_d.rs2       = word_i[24:20];
        packet_d.imm       = imm;
        packet_d.exception = misaligned | illegal;
        // A bad fetch address hides whatever the word decodes to
        if (misaligned) begin
            packet_d.exc_code = `FE_EXC_MISALIGNED;
        end else if (illegal) begin
            packet_d.exc_code = `FE_EXC_ILLEGAL;
        end else begin
            packet_d.exc_code = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            decoded_q.valid <= 1'b0;
        end else if (squash_i) begin
            decoded_q.valid <= 1'b0;
        end else if (!stall_i) begin
            decoded_q <= packet_d;
        end
    end

    assign decoded_o = decoded_q;

endmodule

//--- src/front_end_top.sv
// ====================
// Top level of the instruction-supply front end.
// Connects PC generation, the redirect holding register, the
// instruction buffer and decode between memory and back end.
// ====================

`timescale 1ns/1ps

module front_end_top import frontend_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    output fetch_req_t fetch_req_o,
    input  fetch_rsp_t fetch_rsp_i,
    input  logic       fetch_stall_i,
    input  redirect_t  redirect_i,
    input  logic       stall_i,
    input  logic       m_ext_i,
    output decoded_t   decoded_o
);

    logic        pending;
    logic [31:0] pending_target;
    logic        fetch_blocked;
    logic        squash;
    logic        accepted;
    logic        ibuf_full;
    logic        ibuf_empty;
    logic        ibuf_read;
    logic [31:0] ibuf_word;
    logic [31:0] ibuf_pc;

    // Memory takes the request only when it is not stalling
    assign accepted = fetch_req_o.req & !fetch_stall_i;

    redirect_hold redirect_hold_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .redirect_i       (redirect_i),
        .fetch_blocked_i  (fetch_blocked),
        .pending_o        (pending),
        .pending_target_o (pending_target)
    );

    pc_gen pc_gen_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .redirect_i       (redirect_i),
        .pending_i        (pending),
        .pending_target_i (pending_target),
        .fetch_stall_i    (fetch_stall_i),
        .ibuf_full_i      (ibuf_full),
        .fetch_req_o      (fetch_req_o),
        .fetch_blocked_o  (fetch_blocked),
        .squash_o         (squash)
    );

    instr_buffer instr_buffer_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .squash_i     (squash),
        .accepted_i   (accepted),
        .fetch_addr_i (fetch_req_o.addr),
        .fetch_rsp_i  (fetch_rsp_i),
        .read_i       (ibuf_read),
        .word_o       (ibuf_word),
        .pc_o         (ibuf_pc),
        .empty_o      (ibuf_empty),
        .full_o       (ibuf_full)
    );

    instr_decode instr_decode_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .squash_i  (squash),
        .stall_i   (stall_i),
        .m_ext_i   (m_ext_i),
        .word_i    (ibuf_word),
        .pc_i      (ibuf_pc),
        .empty_i   (ibuf_empty),
        .read_o    (ibuf_read),
        .decoded_o (decoded_o)
    );

endmodule

//--- tests/tb_front_end.sv
// ====================
// Testbench for the instruction-supply front end.
// Models an in-order memory with random latency and fetch stalls, plays
// the back end and checks every decoded packet. Top module is tb_front_end.
// ====================

`timescale 1ns/1ps

`include "frontend_settings.svh"

module tb_front_end import frontend_pkg::*; ();

    localparam logic [31:0] handler_target = 32'h0000_0200;
    localparam logic [31:0] return_target  = 32'h0000_0340;
    localparam logic [31:0] branch_target  = 32'h0000_0480;
    localparam logic [31:0] held_target    = 32'h0000_03c0;
    localparam logic [31:0] odd_target     = 32'h0000_01a2;

    logic       clk_i;
    logic       rst_n_i;
    fetch_req_t fetch_req_o;
    fetch_rsp_t fetch_rsp_i;
    logic       fetch_stall_i;
    redirect_t  redirect_i;
    logic       stall_i;
    logic       m_ext_i;
    decoded_t   decoded_o;

    // Memory model and random source
    logic [31:0] lfsr_q;
    logic [31:0] addr_q [$];
    int          delay_left;
    logic        delay_armed;
    logic        stall_next;
    logic        force_stall;
    logic        rand_stall_en;

    // Back-end model state
    logic        watch_accept;
    logic [31:0] watched_addr;
    logic        req_last;
    logic [31:0] exp_pc;
    logic        m_at_decode;
    logic        stall_prev;
    logic        squash_prev;
    logic        rst_prev;
    decoded_t    decoded_prev;
    int          pkt_count;
    int          errors;
    int          cnt_mul;
    int          cnt_mul_off;
    int          cnt_misaligned;

    front_end_top front_end_top_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_req_o   (fetch_req_o),
        .fetch_rsp_i   (fetch_rsp_i),
        .fetch_stall_i (fetch_stall_i),
        .redirect_i    (redirect_i),
        .stall_i       (stall_i),
        .m_ext_i       (m_ext_i),
        .decoded_o     (decoded_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ====================
    // Reference model
    // ====================

    // One word of every class indexed by address bits 5:2
    function automatic logic [31:0] table_word(input logic [3:0] idx);
        case (idx)
            4'd0:    return 32'h1234_52b7;
            4'd1:    return 32'hffff_f317;
            4'd2:    return 32'hff5f_f0ef;
            4'd3:    return 32'h00c2_8067;
            4'd4:    return 32'hfe53_16e3;
            4'd5:    return 32'h8042_a503;
            4'd6:    return 32'h00a2_a423;
            4'd7:    return 32'h8003_0313;
            4'd8:    return 32'h40b5_0533;
            4'd9:    return 32'h02b5_0533;
            4'd10:   return 32'h0ff0_000f;
            4'd11:   return 32'h0000_0073;
            4'd12:   return 32'hffff_ffff;
            4'd13:   return 32'h00b5_7533;
            4'd14:   return 32'h02c5_c5b3;
            default: return 32'h0000_000b;
        endcase
    endfunction

    function automatic op_class_e class_of_word(input logic [31:0] w, input logic m_on);
        case (w[6:0])
            7'h37:   return OP_LUI;
            7'h17:   return OP_AUIPC;
            7'h6f:   return OP_JAL;
            7'h67:   return OP_JALR;
            7'h63:   return OP_BRANCH;
            7'h03:   return OP_LOAD;
            7'h23:   return OP_STORE;
            7'h13:   return OP_ALU_IMM;
            7'h0f:   return OP_FENCE;
            7'h73:   return OP_SYSTEM;
            7'h33: begin
                if (w[31:25] != 7'h01) begin
                    return OP_ALU_REG;
                end
                return m_on ? OP_MUL : OP_ILLEGAL;
            end
            default: return OP_ILLEGAL;
        endcase
    endfunction

    function automatic logic [31:0] imm_of_word(input logic [31:0] w, input op_class_e cls);
        case (cls)
            OP_LUI, OP_AUIPC: return {w[31:12], 12'h000};
            OP_JAL:    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            OP_BRANCH: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            OP_STORE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            OP_JALR, OP_LOAD, OP_ALU_IMM, OP_FENCE, OP_SYSTEM:
                       return {{20{w[31]}}, w[31:20]};
            default:   return 32'h0;
        endcase
    endfunction

    // Galois LFSR stepped once per bit taken
    function automatic logic lfsr_bit();
        logic b;
        b      = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'hd000_0001;
        end
        return b;
    endfunction

    function automatic logic [3:0] rand_bits(input int n);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[2:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("ERR %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic check_packet(input decoded_t got, input logic m_on);
        logic [31:0] w;
        op_class_e   cls;
        logic        misal;
        logic [4:0]  code;
        w     = table_word(exp_pc[5:2]);
        cls   = class_of_word(w, m_on);
        misal = (exp_pc[1:0] != 2'b00);
        code  = misal ? `FE_EXC_MISALIGNED : ((cls == OP_ILLEGAL) ? `FE_EXC_ILLEGAL : 5'd0);
        assert (got.pc == exp_pc) else report_value("decoded_o.pc", got.pc, exp_pc);
        assert (got.op_class == cls) else report_value("decoded_o.op_class", got.op_class, cls);
        assert (got.rd == w[11:7]) else report_value("decoded_o.rd", got.rd, w[11:7]);
        assert (got.rs1 == w[19:15]) else report_value("decoded_o.rs1", got.rs1, w[19:15]);
        assert (got.rs2 == w[24:20]) else report_value("decoded_o.rs2", got.rs2, w[24:20]);
        assert (got.imm == imm_of_word(w, cls))
            else report_value("decoded_o.imm", got.imm, imm_of_word(w, cls));
        assert (got.exception == (misal || cls == OP_ILLEGAL))
            else report_value("decoded_o.exception", got.exception, misal || cls == OP_ILLEGAL);
        assert (got.exc_code == code) else report_value("decoded_o.exc_code", got.exc_code, code);
        // Coverage counts follow what the DUT actually reported
        if (got.op_class == OP_MUL) begin
            cnt_mul++;
        end
        if (!m_on && w[6:0] == 7'h33 && w[31:25] == 7'h01 && got.exception) begin
            cnt_mul_off++;
        end
        if (got.exception && got.exc_code == `FE_EXC_MISALIGNED) begin
            cnt_misaligned++;
        end
    endtask

    // ====================
    // Per-cycle memory and back-end model
    // ====================

    // Answers the oldest accepted address once its random delay has run out
    task automatic drive_memory();
        logic [31:0] addr;
        fetch_rsp_i = '0;
        if (addr_q.size() > 0) begin
            if (!delay_armed) begin
                delay_left  = rand_bits(2);
                delay_armed = 1'b1;
            end
            if (delay_left == 0) begin
                addr              = addr_q.pop_front();
                fetch_rsp_i.valid = 1'b1;
                fetch_rsp_i.word  = table_word(addr[5:2]);
                delay_armed       = 1'b0;
            end else begin
                delay_left--;
            end
        end
    endtask

    task automatic observe_cycle();
        logic any_redirect;
        any_redirect = redirect_i.exception | redirect_i.handler_return |
                       redirect_i.branch_taken;
        if (!rst_n_i || !rst_prev) begin
            assert (!fetch_req_o.req && !decoded_o.valid)
                else report_problem("fetch strobe or packet valid high around reset");
        end
        if (fetch_req_o.req && !fetch_stall_i) begin
            addr_q.push_back(fetch_req_o.addr);
            if (watch_accept) begin
                watched_addr = fetch_req_o.addr;
                watch_accept = 1'b0;
            end
        end
        req_last = fetch_req_o.req;
        // A stalled back end must see the same packet again
        if (stall_prev && !squash_prev && rst_prev) begin
            assert (decoded_o === decoded_prev) else begin
                $display("ERR decoded_o got %h expected %h", decoded_o, decoded_prev);
                errors++;
            end
        end
        if (decoded_o.valid && !stall_i) begin
            check_packet(decoded_o, m_at_decode);
            pkt_count++;
            exp_pc = exp_pc + 32'd4;
        end
        // The word registered at the next edge is decoded with this level
        if (!stall_i) begin
            m_at_decode = m_ext_i;
        end
        if (redirect_i.exception) begin
            exp_pc = redirect_i.handler_pc;
        end else if (redirect_i.handler_return) begin
            exp_pc = redirect_i.return_pc;
        end else if (redirect_i.branch_taken) begin
            exp_pc = redirect_i.branch_target;
        end
        stall_next = force_stall;
        if (rand_stall_en && rand_bits(2) == 4'd3) begin
            stall_next = 1'b1;
        end
        squash_prev  = any_redirect;
        stall_prev   = stall_i;
        decoded_prev = decoded_o;
        rst_prev     = rst_n_i;
    endtask

    always @(negedge clk_i) begin
        fetch_stall_i = stall_next;
        drive_memory();
        #10;
        observe_cycle();
    end

    // ====================
    // Tests
    // ====================

    task automatic wait_packets(input int n, input int limit);
        int target;
        int cycles;
        target = pkt_count + n;
        cycles = 0;
        while (pkt_count < target && cycles < limit) begin
            @(negedge clk_i);
            cycles++;
        end
        if (pkt_count < target) begin
            $display("timeout: %0d of %0d packets arrived", n - (target - pkt_count), n);
            errors++;
        end
    endtask

    task automatic pulse_redirect(input logic [2:0] flags, input logic [31:0] target);
        redirect_i.exception      = flags[2];
        redirect_i.handler_return = flags[1];
        redirect_i.branch_taken   = flags[0];
        redirect_i.handler_pc     = handler_target;
        redirect_i.return_pc      = return_target;
        redirect_i.branch_target  = target;
        @(negedge clk_i);
        redirect_i = '0;
    endtask

    task automatic report_test(input string name, input int e0);
        $display("%-20s %s", name, (errors == e0) ? "ok" : "failed");
    endtask

    task automatic seq_fetch();
        int e0;
        e0            = errors;
        rand_stall_en = 1'b1;
        wait_packets(40, 600);
        report_test("sequential fetch", e0);
    endtask

    task automatic decode_classes();
        int e0;
        e0      = errors;
        m_ext_i = 1'b1;
        wait_packets(16, 400);
        m_ext_i = 1'b0;
        wait_packets(20, 400);
        m_ext_i = 1'b1;
        assert (cnt_mul > 0) else report_problem("no M word decoded with the extension on");
        assert (cnt_mul_off > 0) else report_problem("no M word decoded with the extension off");
        report_test("decode", e0);
    endtask

    task automatic redirect_priority();
        int e0;
        e0 = errors;
        pulse_redirect(3'b111, branch_target);
        wait_packets(5, 200);
        pulse_redirect(3'b110, branch_target);
        wait_packets(5, 200);
        pulse_redirect(3'b101, branch_target);
        wait_packets(5, 200);
        pulse_redirect(3'b011, branch_target);
        wait_packets(5, 200);
        report_test("redirect priority", e0);
    endtask

    task automatic held_redirect();
        int e0;
        int cycles;
        e0            = errors;
        rand_stall_en = 1'b0;
        force_stall   = 1'b1;
        repeat (3) @(negedge clk_i);
        pulse_redirect(3'b001, held_target);
        repeat (3) @(negedge clk_i);
        watch_accept = 1'b1;
        force_stall  = 1'b0;
        cycles       = 0;
        while (watch_accept && cycles < 40) begin
            @(negedge clk_i);
            cycles++;
        end
        if (watch_accept) begin
            report_problem("no fetch request was accepted after the fetch stall ended");
        end else begin
            assert (watched_addr == held_target)
                else report_value("fetch_req_o.addr", watched_addr, held_target);
        end
        wait_packets(4, 200);
        rand_stall_en = 1'b1;
        report_test("held redirect", e0);
    endtask

    task automatic back_pressure();
        int e0;
        e0            = errors;
        rand_stall_en = 1'b0;
        wait_packets(2, 100);
        stall_i = 1'b1;
        repeat (10) @(negedge clk_i);
        // Four words stored or in flight leave no room for another request
        assert (!req_last) else report_problem("fetch strobe stayed high with the buffer full");
        stall_i = 1'b0;
        wait_packets(12, 300);
        rand_stall_en = 1'b1;
        report_test("back-pressure", e0);
    endtask

    task automatic misaligned_target();
        int e0;
        e0 = errors;
        pulse_redirect(3'b001, odd_target);
        wait_packets(3, 200);
        assert (cnt_misaligned > 0) else report_problem("no packet from a misaligned address");
        pulse_redirect(3'b001, `FE_RESET_PC);
        wait_packets(4, 200);
        report_test("misaligned target", e0);
    endtask

    initial begin
        rst_n_i        = 1'b0;
        fetch_rsp_i    = '0;
        fetch_stall_i  = 1'b0;
        redirect_i     = '0;
        stall_i        = 1'b0;
        m_ext_i        = 1'b1;
        lfsr_q         = 32'hb0c7;
        delay_left     = 0;
        delay_armed    = 1'b0;
        stall_next     = 1'b0;
        force_stall    = 1'b0;
        rand_stall_en  = 1'b0;
        watch_accept   = 1'b0;
        watched_addr   = '0;
        req_last       = 1'b0;
        exp_pc         = `FE_RESET_PC;
        m_at_decode    = 1'b1;
        stall_prev     = 1'b0;
        squash_prev    = 1'b0;
        rst_prev       = 1'b0;
        decoded_prev   = '0;
        pkt_count      = 0;
        errors         = 0;
        cnt_mul        = 0;
        cnt_mul_off    = 0;
        cnt_misaligned = 0;
        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;

        seq_fetch();
        decode_classes();
        redirect_priority();
        held_redirect();
        back_pressure();
        misaligned_target();

        $display("packets checked %0d, errors %0d", pkt_count, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+src
src/frontend_pkg.sv
src/redirect_hold.sv
src/pc_gen.sv
src/instr_buffer.sv
src/instr_decode.sv
src/front_end_top.sv
tests/tb_front_end.sv
